//--- include/arbiter_defines.svh
`ifndef ARBITER_DEFINES_SVH
`define ARBITER_DEFINES_SVH

// address and cacheline geometry of the memory port
`define ADDR_BITS 32
`define LINE_BITS 256

// byte offset bits inside one line, 32 bytes per line
`define OFFSET_BITS 5

`endif

//--- design/rv32i_types_pkg.sv
`include "arbiter_defines.svh"

package rv32i_types_pkg;

    // ##############################
    // core word types
    // ##############################

    // one word of the core, used for both addresses and data
    typedef logic [`ADDR_BITS-1:0] rv32i_word;

endpackage

//--- design/cache_types_pkg.sv
`include "arbiter_defines.svh"

package cache_types_pkg;

    // ##############################
    // line and arbiter types
    // ##############################

    typedef logic [`LINE_BITS-1:0] cacheline; // one line as moved to and from memory

    // grant states of the arbiter, only one owner of the memory port at a time
    typedef enum logic [1:0] {
        idle,
        icache,
        dcache,
        prefetch
    } arb_state;

    // request kinds seen by the arbiter
    // used both for the request being served and for the one waiting behind it
    typedef enum logic [2:0] {
        none,
        iread,
        dread,
        dwrite,
        pf
    } arb_request;

endpackage

//--- design/prefetch_buffer.sv
`timescale 1ns/1ps

`include "arbiter_defines.svh"

module prefetch_buffer
    import rv32i_types_pkg::*;
    import cache_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  rv32i_word pf_addr,
    input  logic      pf_read,   // lookup on behalf of the instruction cache
    input  logic      pf_write,  // lookup on behalf of a running prefetch
    input  logic      pf_ld,
    input  cacheline  pf_data_w,

    output cacheline  pf_data_r,
    output logic      pf_hit,
    output logic      pf_miss,
    output logic      pf_resp
);

    localparam int TAG_BITS = `ADDR_BITS - `OFFSET_BITS;

    logic                buf_valid;
    logic [TAG_BITS-1:0] buf_tag;
    cacheline            buf_line;

    logic                lookup;
    logic                tag_match;

    // ##############################
    // lookup
    // ##############################

    assign lookup    = pf_read | pf_write;
    assign tag_match = buf_valid && (buf_tag == pf_addr[`ADDR_BITS-1:`OFFSET_BITS]);

    assign pf_hit    = lookup & tag_match;
    assign pf_miss   = lookup & ~tag_match;
    assign pf_data_r = buf_line;

    // the load is taken at the edge where pf_ld is high, so it is acknowledged right away
    assign pf_resp   = pf_ld;

    // ##############################
    // storage
    // ##############################

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            buf_valid <= 1'b0;
        end else if (pf_ld) begin
            buf_valid <= 1'b1;
        end
    end

    // the line and its tag only mean something once buf_valid is set
    always_ff @(posedge clk) begin
        if (pf_ld) begin
            buf_tag  <= pf_addr[`ADDR_BITS-1:`OFFSET_BITS];
            buf_line <= pf_data_w;
        end
    end

endmodule

//--- design/cache_arbiter.sv
`timescale 1ns/1ps

`include "arbiter_defines.svh"

module cache_arbiter
    import rv32i_types_pkg::*;
    import cache_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // the instruction cache only reads
    input  rv32i_word icache_addr,
    input  logic      icache_read,
    output cacheline  icache_data,
    output logic      icache_resp,

    // data cache
    input  rv32i_word dcache_addr,
    input  cacheline  dcache_data_w,
    input  logic      dcache_read,
    input  logic      dcache_write,
    output cacheline  dcache_data_r,
    output logic      dcache_resp,

    input  rv32i_word pc_rdata,

    // prefetch buffer
    input  cacheline  pf_data_r,
    input  logic      pf_hit,
    input  logic      pf_miss,
    input  logic      pf_resp,
    output rv32i_word pf_addr,
    output logic      pf_read,
    output logic      pf_write,
    output logic      pf_ld,
    output cacheline  pf_data_w,

    // physical memory
    input  cacheline  mem_data_r,
    input  logic      mem_resp,
    output rv32i_word mem_addr,
    output cacheline  mem_data_w,
    output logic      mem_read,
    output logic      mem_write
);

    arb_state   state;
    arb_state   next_state;
    arb_request current_request;
    arb_request pending_request;

    rv32i_word  pc_line_base;
    rv32i_word  pf_next_addr;
    rv32i_word  pf_fill_addr;   // the line being prefetched stays frozen for the whole fill

    // ##############################
    // request tracking
    // ##############################

    // a cache that is being served cannot send another request, and a cache that waits
    // cannot be the one being served, so at most one request is ever pending
    always_comb begin
        current_request = none;
        pending_request = none;
        case (state)
            icache: begin
                current_request = iread;
                if (dcache_read) begin
                    pending_request = dread;
                end else if (dcache_write) begin
                    pending_request = dwrite;
                end
            end
            dcache: begin
                current_request = dcache_write ? dwrite : dread;
                if (icache_read) begin
                    pending_request = iread;
                end
            end
            prefetch: begin
                current_request = pf;
                if (icache_read) begin
                    pending_request = iread; // instruction side still wins afterwards
                end else if (dcache_read) begin
                    pending_request = dread;
                end else if (dcache_write) begin
                    pending_request = dwrite;
                end
            end
            default: ;
        endcase
    end

    // ##############################
    // prefetch address
    // ##############################

    // the next line after the program counter carries into the upper bits
    assign pc_line_base = {pc_rdata[`ADDR_BITS-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
    assign pf_next_addr = pc_line_base + (rv32i_word'(1) << `OFFSET_BITS);

    always_ff @(posedge clk) begin
        if (state == idle && next_state == prefetch) begin
            pf_fill_addr <= pf_next_addr;
        end
    end

    // ##############################
    // port steering
    // ##############################

    // the buffer lookup only depends on the state and the requesters, never on its own answer
    always_comb begin
        pf_addr  = pf_fill_addr;
        pf_read  = 1'b0;
        pf_write = 1'b0;
        case (state)
            icache: begin
                pf_addr = icache_addr;
                pf_read = icache_read;
            end
            prefetch: begin
                pf_write = 1'b1; // lookup of the line we are about to fill
            end
            default: ;
        endcase
    end

    always_comb begin
        icache_data   = '0;
        icache_resp   = 1'b0;
        dcache_data_r = '0;
        dcache_resp   = 1'b0;
        pf_ld         = 1'b0;
        pf_data_w     = '0;
        mem_addr      = '0;
        mem_data_w    = '0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;

        case (state)
            icache: begin
                // the buffer is asked first and memory only sees the fetch on a miss
                if (pf_hit) begin
                    icache_resp = 1'b1;
                    icache_data = pf_data_r;
                end else if (pf_miss) begin
                    mem_addr    = icache_addr;
                    mem_read    = 1'b1;
                    icache_resp = mem_resp;
                    icache_data = mem_data_r;
                end
            end
            dcache: begin
                mem_addr      = dcache_addr;
                mem_data_w    = dcache_data_w;
                mem_read      = (current_request == dread);
                mem_write     = (current_request == dwrite);
                dcache_resp   = mem_resp;
                dcache_data_r = mem_data_r;
            end
            prefetch: begin
                pf_ld     = mem_resp;
                pf_data_w = mem_data_r;
                if (pf_miss) begin
                    mem_addr = pf_fill_addr;
                    mem_read = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // ##############################
    // grant state machine
    // ##############################

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (icache_read) begin
                    next_state = icache;
                end else if (dcache_read || dcache_write) begin
                    next_state = dcache;
                end else begin
                    next_state = prefetch; // both caches quiet
                end
            end
            icache: begin
                if (pf_hit || mem_resp) begin
                    if (pending_request == dread || pending_request == dwrite) begin
                        next_state = dcache;
                    end else begin
                        next_state = idle;
                    end
                end
            end
            dcache: begin
                if (mem_resp) begin
                    next_state = (pending_request == iread) ? icache : idle;
                end
            end
            prefetch: begin
                // a running fill is finished first and waiting caches keep holding
                if (pf_hit || pf_resp) begin
                    next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

endmodule

//--- design/memory_subsystem.sv
`timescale 1ns/1ps

module memory_subsystem
    import rv32i_types_pkg::*;
    import cache_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  rv32i_word icache_addr,
    input  logic      icache_read,
    output cacheline  icache_data,
    output logic      icache_resp,

    input  rv32i_word dcache_addr,
    input  cacheline  dcache_data_w,
    input  logic      dcache_read,
    input  logic      dcache_write,
    output cacheline  dcache_data_r,
    output logic      dcache_resp,

    input  rv32i_word pc_rdata,

    input  cacheline  mem_data_r,
    input  logic      mem_resp,
    output rv32i_word mem_addr,
    output cacheline  mem_data_w,
    output logic      mem_read,
    output logic      mem_write
);

    // arbiter to prefetch buffer
    rv32i_word pf_addr;
    logic      pf_read;
    logic      pf_write;
    logic      pf_ld;
    cacheline  pf_data_w;
    cacheline  pf_data_r;
    logic      pf_hit;
    logic      pf_miss;
    logic      pf_resp;

    cache_arbiter arbiter0 (
        .clk           (clk),
        .reset         (reset),
        .icache_addr   (icache_addr),
        .icache_read   (icache_read),
        .icache_data   (icache_data),
        .icache_resp   (icache_resp),
        .dcache_addr   (dcache_addr),
        .dcache_data_w (dcache_data_w),
        .dcache_read   (dcache_read),
        .dcache_write  (dcache_write),
        .dcache_data_r (dcache_data_r),
        .dcache_resp   (dcache_resp),
        .pc_rdata      (pc_rdata),
        .pf_data_r     (pf_data_r),
        .pf_hit        (pf_hit),
        .pf_miss       (pf_miss),
        .pf_resp       (pf_resp),
        .pf_addr       (pf_addr),
        .pf_read       (pf_read),
        .pf_write      (pf_write),
        .pf_ld         (pf_ld),
        .pf_data_w     (pf_data_w),
        .mem_data_r    (mem_data_r),
        .mem_resp      (mem_resp),
        .mem_addr      (mem_addr),
        .mem_data_w    (mem_data_w),
        .mem_read      (mem_read),
        .mem_write     (mem_write)
    );

    // single line buffer, filled only by the arbiter's prefetch state
    prefetch_buffer pf_buffer0 (
        .clk       (clk),
        .reset     (reset),
        .pf_addr   (pf_addr),
        .pf_read   (pf_read),
        .pf_write  (pf_write),
        .pf_ld     (pf_ld),
        .pf_data_w (pf_data_w),
        .pf_data_r (pf_data_r),
        .pf_hit    (pf_hit),
        .pf_miss   (pf_miss),
        .pf_resp   (pf_resp)
    );

endmodule

//--- testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset
);

    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    // reset lets go a little after a rising edge, like every other DUT input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

//--- testbench/line_memory_model.sv
`timescale 1ns/1ps

`include "arbiter_defines.svh"

module line_memory_model
    import rv32i_types_pkg::*;
    import cache_types_pkg::*;
#(
    parameter int unsigned seed = 0
) (
    input  logic      clk,
    input  logic      reset,
    input  rv32i_word mem_addr,
    input  cacheline  mem_data_w,
    input  logic      mem_read,
    input  logic      mem_write,
    output cacheline  mem_data_r,
    output logic      mem_resp,
    output int        read_count,     // reads accepted since the start of the run
    output rv32i_word last_read_addr,
    output rv32i_word prev_read_addr  // the read just before the last one
);

    cacheline stored [rv32i_word]; // written lines, keyed by line address

    // unwritten memory holds the line address plus the word index in every word
    function automatic cacheline fill_pattern(rv32i_word base);
        cacheline line;

        for (int i = 0; i < `LINE_BITS / 32; i++) begin
            line[32*i +: 32] = base + rv32i_word'(i);
        end
        return line;
    endfunction

    initial begin
        rv32i_word addr;
        logic      is_write;
        int        latency;

        mem_data_r     = '0;
        mem_resp       = 1'b0;
        read_count     = 0;
        last_read_addr = '0;
        prev_read_addr = '0;
        void'($urandom(seed));
        forever begin
            @(negedge clk); // requests are looked at mid-cycle
            if (!reset && (mem_read || mem_write)) begin
                addr     = {mem_addr[`ADDR_BITS-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
                is_write = mem_write;
                latency  = $urandom_range(6, 1);
                if (is_write) begin
                    stored[addr] = mem_data_w;
                end else begin
                    read_count++;
                    prev_read_addr = last_read_addr;
                    last_read_addr = mem_addr;
                end
                repeat (latency) @(posedge clk);
                #1;
                if (!is_write) begin
                    mem_data_r = stored.exists(addr) ? stored[addr] : fill_pattern(addr);
                end
                mem_resp = 1'b1;
                @(posedge clk);
                #1;
                mem_resp = 1'b0; // the arbiter has moved on by the next negedge
            end
        end
    end

endmodule

//--- testbench/memory_subsystem_tb.sv
`timescale 1ns/1ps

`include "arbiter_defines.svh"

module memory_subsystem_tb
    import rv32i_types_pkg::*;
    import cache_types_pkg::*;
();

    localparam int unsigned rand_seed    = 32'h1dae_c906;
    localparam int          resp_timeout = 200;
    localparam int          quiet_cycles = 40;
    localparam int          num_rows     = 8;
    localparam cacheline    store_line   =
        256'hdead_beef_0123_4567_89ab_cdef_0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0_1357_9bdf;

    typedef enum {op_ifetch, op_dload, op_dstore, op_both, op_idle} op_kind;

    typedef struct {
        string     name;
        op_kind    op;
        rv32i_word addr;      // fetch or data address, or the expected prefetch line when idle
        rv32i_word d_addr;    // data side of a combined row
        cacheline  wdata;
        rv32i_word pc;
        cacheline  exp_line;
        int        exp_reads; // memory reads the row should cause
    } stim_row;

    logic      clk;
    logic      reset;
    rv32i_word icache_addr;
    logic      icache_read;
    cacheline  icache_data;
    logic      icache_resp;
    rv32i_word dcache_addr;
    cacheline  dcache_data_w;
    logic      dcache_read;
    logic      dcache_write;
    cacheline  dcache_data_r;
    logic      dcache_resp;
    rv32i_word pc_rdata;
    rv32i_word mem_addr;
    cacheline  mem_data_w;
    cacheline  mem_data_r;
    logic      mem_read;
    logic      mem_write;
    logic      mem_resp;
    int        read_count;
    rv32i_word last_read_addr;
    rv32i_word prev_read_addr;

    stim_row   rows [num_rows];
    int        checks;
    int        value_errors;
    int        other_errors;
    bit        aborted;

    clock_gen clock_gen0 (.clk(clk), .reset(reset));

    memory_subsystem dut0 (.*);

    line_memory_model #(.seed(rand_seed)) mem_model0 (.*);

    // ##############################
    // expected values and checks
    // ##############################

    function automatic cacheline pattern_line(rv32i_word addr);
        cacheline  line;
        rv32i_word base;

        base = {addr[`ADDR_BITS-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
        for (int i = 0; i < `LINE_BITS / 32; i++) begin
            line[32*i +: 32] = base + rv32i_word'(i);
        end
        return line;
    endfunction

    task automatic compare_line(input string name, input cacheline exp, input cacheline act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, got %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_word(input string name, input rv32i_word exp, input rv32i_word act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, got %h", name, exp, act);
            value_errors++;
        end
    endtask

    // no strobe may be active while the arbiter sits in reset or has just left it
    task automatic check_quiet(input string name);
        checks++;
        assert ({mem_read, mem_write, icache_resp, dcache_resp} === 4'b0000) else begin
            $display("[FAIL] %s: expected %b, got %b (mem_read mem_write icache_resp dcache_resp)",
                     name, 4'b0000, {mem_read, mem_write, icache_resp, dcache_resp});
            value_errors++;
        end
    endtask

    task automatic check_reset();
        int cycles;

        cycles = 0;
        do begin
            @(negedge clk);
            if (reset) begin
                check_quiet("during_reset");
            end else begin
                check_quiet("after_reset");
            end
            cycles++;
        end while (reset && cycles < 20);
        if (reset) begin
            $display("timeout: reset was never released");
            other_errors++;
            aborted = 1'b1;
        end
        @(posedge clk);
        #1;
    endtask

    // ##############################
    // stimulus
    // ##############################

    task automatic wait_resp(input string name, input bit want_i, input bit want_d,
                             output cacheline i_line, output cacheline d_line);
        bit i_open;
        bit d_open;
        int cycles;

        i_open = want_i;
        d_open = want_d;
        i_line = '0;
        d_line = '0;
        cycles = 0;
        while ((i_open || d_open) && cycles < resp_timeout) begin
            @(negedge clk);
            if (i_open && icache_resp) begin
                i_line = icache_data;
                i_open = 1'b0;
            end
            if (d_open && dcache_resp) begin
                d_line = dcache_data_r;
                d_open = 1'b0;
            end
            @(posedge clk);
            #1;
            if (!i_open) begin
                icache_read = 1'b0; // a requester lets go on the cycle after its resp
            end
            if (!d_open) begin
                dcache_read  = 1'b0;
                dcache_write = 1'b0;
            end
            cycles++;
        end
        if (i_open || d_open) begin
            $display("timeout: %s got no resp within %0d cycles", name, resp_timeout);
            other_errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic run_row(input stim_row row);
        int       reads_before;
        cacheline i_line;
        cacheline d_line;

        pc_rdata     = row.pc;
        reads_before = read_count;
        i_line       = '0;
        d_line       = '0;
        if (row.op == op_idle) begin
            repeat (quiet_cycles) @(posedge clk);
            #1;
        end else begin
            icache_addr   = row.addr;
            icache_read   = (row.op == op_ifetch || row.op == op_both);
            dcache_addr   = (row.op == op_both) ? row.d_addr : row.addr;
            dcache_data_w = row.wdata;
            dcache_read   = (row.op == op_dload || row.op == op_both);
            dcache_write  = (row.op == op_dstore);
            wait_resp(row.name, icache_read, dcache_read | dcache_write, i_line, d_line);
        end
        if (!aborted) begin
            compare_word({row.name, " read count"}, row.exp_reads, read_count - reads_before);
            case (row.op)
                op_ifetch: compare_line(row.name, row.exp_line, i_line);
                op_dload:  compare_line(row.name, row.exp_line, d_line);
                op_both: begin
                    compare_line({row.name, " icache"}, row.exp_line, i_line);
                    compare_line({row.name, " dcache"}, pattern_line(row.d_addr), d_line);
                    compare_word({row.name, " first read"}, row.addr, prev_read_addr);
                end
                default: ;
            endcase
            if (row.exp_reads > 0) begin
                compare_word({row.name, " last read"},
                             (row.op == op_both) ? row.d_addr : row.addr, last_read_addr);
            end
        end
    endtask

    initial begin
        icache_addr   = '0;
        icache_read   = 1'b0;
        dcache_addr   = '0;
        dcache_data_w = '0;
        dcache_read   = 1'b0;
        dcache_write  = 1'b0;
        pc_rdata      = '0;
        checks        = 0;
        value_errors  = 0;
        other_errors  = 0;
        aborted       = 1'b0;

        // the line after pc 0 is 0x20, the line after pc 0x6004 is 0x6020
        rows[0] = '{"prefetch_after_reset", op_idle, 32'h0000_0020, '0, '0, '0, '0, 1};
        rows[1] = '{"ifetch_miss", op_ifetch, 32'h0000_1000, '0, '0, '0,
                    pattern_line(32'h0000_1000), 1};
        rows[2] = '{"dstore", op_dstore, 32'h0000_2040, '0, store_line, '0, '0, 0};
        rows[3] = '{"dload_stored", op_dload, 32'h0000_2040, '0, '0, '0, store_line, 1};
        rows[4] = '{"dload_other", op_dload, 32'h0000_3000, '0, '0, '0,
                    pattern_line(32'h0000_3000), 1};
        rows[5] = '{"both_requests", op_both, 32'h0000_4000, 32'h0000_5000, '0, '0,
                    pattern_line(32'h0000_4000), 2};
        rows[6] = '{"prefetch_next_line", op_idle, 32'h0000_6020, '0, '0, 32'h0000_6004, '0, 1};
        rows[7] = '{"ifetch_prefetch_hit", op_ifetch, 32'h0000_6020, '0, '0, 32'h0000_6004,
                    pattern_line(32'h0000_6020), 0}; // answered from the buffer

        check_reset();
        for (int r = 0; r < num_rows && !aborted; r++) begin
            run_row(rows[r]);
        end

        $display("checks run: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
design/rv32i_types_pkg.sv
design/cache_types_pkg.sv
design/prefetch_buffer.sv
design/cache_arbiter.sv
design/memory_subsystem.sv
testbench/clock_gen.sv
testbench/line_memory_model.sv
testbench/memory_subsystem_tb.sv

//--- Makefile
TOP := memory_subsystem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f sources.f

sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -Mdir obj_dir -f sources.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
